// File: hdl/fcb_pif_top.sv
// Parallel configuration port top level
// Port-on gating, write sequencer, assembler and read serializer
`default_nettype none

module fcb_pif_top
(
  input  wire logic                           fcb_sys_clk,
  input  wire logic                           fcb_sys_rst_n,
  input  wire logic                           fcb_sys_stm,       // Test mode
  input  wire logic                           fcb_pif_en,        // Port enable
  input  wire logic                           fcb_pif_vldi,
  input  wire logic [pif_pkg::PIF_BYTE_W-1:0] fcb_pif_di,
  input  wire logic                           frwf_crf_empty,
  input  wire logic [pif_pkg::PIF_WORD_W-1:0] frwf_crf_rd_data,
  output pif_pkg::pif_pad_t                   fcb_pif_pad,
  output logic                                fpif_frwf_pif_on,
  output logic                                fpif_frwf_wff_wr_en,
  output logic                                fpif_frwf_crf_rd_en,
  output pif_pkg::pif_wr_entry_t              fpif_frwf_wff_wr_data
);

  import pif_pkg::*;

  logic      pif_on;
  pif_load_t load;  // Sequencer to assembler

  assign pif_on           = fcb_sys_stm & fcb_pif_en;
  assign fpif_frwf_pif_on = pif_on;

  pif_wr_fsm pif_wr_fsm_i (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .pif_on        (pif_on),
    .vldi          (fcb_pif_vldi),
    .din           (fcb_pif_di),
    .load          (load),
    .wr_en         (fpif_frwf_wff_wr_en)
  );

  pif_wr_assembler pif_wr_assembler_i (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .pif_on        (pif_on),
    .din           (fcb_pif_di),
    .load          (load),
    .entry         (fpif_frwf_wff_wr_data)
  );

  pif_rd_serializer pif_rd_serializer_i (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .pif_on        (pif_on),
    .crf_empty     (frwf_crf_empty),
    .crf_data      (frwf_crf_rd_data),
    .crf_rd_en     (fpif_frwf_crf_rd_en),
    .pad           (fcb_pif_pad)
  );

endmodule

`default_nettype wire

// File: hdl/pif_pkg.sv
// Shared definitions for the parallel configuration port
// Byte and word widths, fixed burst address, FSM state enums
// Write-FIFO entry, load strobe and pad bundles
`default_nettype none

package pif_pkg;

  localparam int PIF_BYTE_W     = 8;                          // One host byte
  localparam int PIF_WORD_BYTES = 4;                          // Bytes per data word
  localparam int PIF_WORD_W     = PIF_BYTE_W * PIF_WORD_BYTES; // 32-bit data word
  localparam int PIF_LONG_BIT   = 7;                          // Address bit for long write

  // Port address that holds during a burst
  localparam logic [PIF_BYTE_W-1:0] PIF_FIXED_ADDR = 8'hA0;

  // Write sequencer
  typedef enum logic [2:0] {
    WR_OFF   = 3'd0,  // Port off
    WR_ADDR  = 3'd1,  // Waiting for address byte
    WR_SHORT = 3'd2,  // Short command, push entry
    WR_B0    = 3'd3,
    WR_B1    = 3'd4,
    WR_B2    = 3'd5,
    WR_B3    = 3'd6,  // Last data byte, push entry
    WR_BURST = 3'd7   // Next group or back to idle
  } pif_wr_state_e;

  // Read sequencer
  typedef enum logic [2:0] {
    RD_OFF = 3'd0,
    RD_B0  = 3'd1,  // Waits on FIFO not empty
    RD_B1  = 3'd2,
    RD_B2  = 3'd3,
    RD_B3  = 3'd4   // Pops the FIFO
  } pif_rd_state_e;

  // Write-FIFO entry, address on top
  typedef struct packed {
    logic [PIF_BYTE_W-1:0] addr;
    logic [PIF_WORD_W-1:0] data;
  } pif_wr_entry_t;

  // Sequencer to assembler strobes
  typedef struct packed {
    logic                      load_addr;  // Capture address byte
    logic [PIF_WORD_BYTES-1:0] load_byte;  // One per data byte
    logic                      next_beat;  // Burst continues
  } pif_load_t;

  // Host-side outputs
  typedef struct packed {
    logic                  vldo;
    logic                  vldo_en;
    logic [PIF_BYTE_W-1:0] dout;
    logic                  dout_en;
  } pif_pad_t;

endpackage

`default_nettype wire

// File: hdl/pif_rd_serializer.sv
// Read-back path of the parallel configuration port
// Unloads one config read FIFO word as four bytes, then pops it
// Pad output-enables
`default_nettype none

module pif_rd_serializer
(
  input  wire logic                           fcb_sys_clk,
  input  wire logic                           fcb_sys_rst_n,
  input  wire logic                           pif_on,
  input  wire logic                           crf_empty,  // Read FIFO empty
  input  wire logic [pif_pkg::PIF_WORD_W-1:0] crf_data,   // Read FIFO head word
  output logic                                crf_rd_en,  // Pop after byte 3
  output pif_pkg::pif_pad_t                   pad
);

  import pif_pkg::*;

  pif_rd_state_e state_q;
  pif_rd_state_e state_ns;

  logic [$clog2(PIF_WORD_BYTES)-1:0] byte_sel;
  logic                              vldo;

  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n)
  begin
    if (!fcb_sys_rst_n)
    begin
      state_q <= RD_OFF;
    end
    else if (pif_on)
    begin
      state_q <= state_ns;
    end
    else
    begin
      state_q <= RD_OFF;  // Restart from byte 0 next time
    end
  end

  always_comb
  begin
    state_ns  = state_q;
    byte_sel  = '0;
    vldo      = 1'b0;
    crf_rd_en = 1'b0;

    case (state_q)
      RD_OFF:  state_ns = RD_B0;
      RD_B0:
      begin
        if (!crf_empty)
        begin
          vldo     = 1'b1;  // Byte 0 straight off the FIFO head
          state_ns = RD_B1;
        end
      end
      RD_B1:
      begin
        byte_sel = 2'd1;
        vldo     = 1'b1;
        state_ns = RD_B2;
      end
      RD_B2:
      begin
        byte_sel = 2'd2;
        vldo     = 1'b1;
        state_ns = RD_B3;
      end
      RD_B3:
      begin
        byte_sel  = 2'd3;
        vldo      = 1'b1;
        crf_rd_en = 1'b1;
        state_ns  = RD_B0;  // Back to back if more words
      end
      default: state_ns = RD_OFF;
    endcase

    // Quiet pads and no pop once the port drops
    if (!pif_on)
    begin
      vldo      = 1'b0;
      crf_rd_en = 1'b0;
    end
  end

  // Byte mux and pad drive
  assign pad.dout    = crf_data[byte_sel*PIF_BYTE_W +: PIF_BYTE_W];
  assign pad.vldo    = vldo;
  assign pad.vldo_en = pif_on;  // Low when port is off
  assign pad.dout_en = vldo;

  // Pop only at byte 3, after three gapless bytes
  a_rd_en_b3 : assert property (
    @(posedge fcb_sys_clk) disable iff (!fcb_sys_rst_n)
    crf_rd_en |-> (state_q == RD_B3) && $past(vldo) && $past(vldo, 2) && $past(vldo, 3)
  ) else $error("crf_rd_en outside byte 3");

endmodule

`default_nettype wire

// File: hdl/pif_wr_assembler.sv
// Address and data byte registers for the write path
// Burst address increment with fixed-address hold
// Write-FIFO entry formation
`default_nettype none

module pif_wr_assembler
(
  input  wire logic                           fcb_sys_clk,
  input  wire logic                           fcb_sys_rst_n,
  input  wire logic                           pif_on,
  input  wire logic [pif_pkg::PIF_BYTE_W-1:0] din,    // Live host byte
  input  wire pif_pkg::pif_load_t             load,   // From sequencer
  output pif_pkg::pif_wr_entry_t              entry   // To write FIFO
);

  import pif_pkg::*;

  logic [PIF_BYTE_W-1:0] addr_q;
  logic [PIF_BYTE_W-1:0] data_q [0:PIF_WORD_BYTES-2];  // Bytes 0 to 2
  logic [PIF_BYTE_W-1:0] top_byte;

  // Address register, also the burst counter
  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n)
  begin
    if (!fcb_sys_rst_n)
    begin
      addr_q <= '0;
    end
    else if (pif_on)
    begin
      if (load.load_addr)
      begin
        addr_q <= din;
      end
      else if (load.next_beat && (addr_q != PIF_FIXED_ADDR))
      begin
        addr_q <= addr_q + 1'b1;  // Next register in the burst
      end
    end
  end

  // Lower data bytes
  always_ff @(posedge fcb_sys_clk)
  begin
    for (int i = 0; i < PIF_WORD_BYTES - 1; i++)
    begin
      if (pif_on && load.load_byte[i])
      begin
        data_q[i] <= din;
      end
    end
  end

  // Byte 3 is taken live in its own cycle
  assign top_byte = load.load_byte[3] ? din : '0;

  always_comb
  begin
    entry.addr = addr_q;
    if (addr_q[PIF_LONG_BIT])
    begin
      entry.data = {top_byte, data_q[2], data_q[1], data_q[0]};  // LSB first on the bus
    end
    else
    begin
      entry.data = '0;  // Short command carries no data
    end
  end

endmodule

`default_nettype wire

// File: hdl/pif_wr_fsm.sv
// Write sequencer for the host byte stream
// Tracks address and data bytes, issues load strobes and FIFO push
`default_nettype none

module pif_wr_fsm
(
  input  wire logic                           fcb_sys_clk,
  input  wire logic                           fcb_sys_rst_n,
  input  wire logic                           pif_on,   // Test mode and port enable
  input  wire logic                           vldi,     // Host byte strobe
  input  wire logic [pif_pkg::PIF_BYTE_W-1:0] din,      // Host byte
  output pif_pkg::pif_load_t                  load,     // Strobes to assembler
  output logic                                wr_en     // Write-FIFO push
);

  import pif_pkg::*;

  pif_wr_state_e state_q;
  pif_wr_state_e state_ns;

  // State register, forced to OFF while port is off
  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n)
  begin
    if (!fcb_sys_rst_n)
    begin
      state_q <= WR_OFF;
    end
    else if (pif_on)
    begin
      state_q <= state_ns;
    end
    else
    begin
      state_q <= WR_OFF;
    end
  end

  // Next state and strobes
  always_comb
  begin
    state_ns = state_q;
    load     = '0;
    wr_en    = 1'b0;

    case (state_q)
      WR_OFF:
      begin
        state_ns = WR_ADDR;  // Only reached with pif_on high
      end

      WR_ADDR:
      begin
        if (vldi)
        begin
          load.load_addr = 1'b1;
          // Bit 7 picks long write
          if (din[PIF_LONG_BIT])
          begin
            state_ns = WR_B0;
          end
          else
          begin
            state_ns = WR_SHORT;
          end
        end
      end

      WR_SHORT:
      begin
        wr_en    = 1'b1;  // One cycle after the address byte
        state_ns = WR_ADDR;
      end

      WR_B0:
      begin
        if (vldi)
        begin
          load.load_byte[0] = 1'b1;
          state_ns          = WR_B1;
        end
      end

      WR_B1:
      begin
        if (vldi)
        begin
          load.load_byte[1] = 1'b1;
          state_ns          = WR_B2;
        end
      end

      WR_B2:
      begin
        if (vldi)
        begin
          load.load_byte[2] = 1'b1;
          state_ns          = WR_B3;
        end
      end

      WR_B3:
      begin
        // Top byte goes straight from din into the entry
        if (vldi)
        begin
          load.load_byte[3] = 1'b1;
          wr_en             = 1'b1;
          state_ns          = WR_BURST;
        end
      end

      WR_BURST:
      begin
        if (vldi)
        begin
          load.load_byte[0] = 1'b1;  // First byte of next group
          load.next_beat    = 1'b1;  // Bump address
          state_ns          = WR_B1;
        end
        else
        begin
          state_ns = WR_ADDR;  // Gap ends the burst
        end
      end

      default:
      begin
        state_ns = WR_OFF;
      end
    endcase

    // Port falling mid-command, drop the push
    if (!pif_on)
    begin
      wr_en = 1'b0;
    end
  end

  // Push needs the port on now and on the previous edge
  a_wr_en_port_on : assert property (
    @(posedge fcb_sys_clk) disable iff (!fcb_sys_rst_n)
    wr_en |-> pif_on && $past(pif_on)
  ) else $error("wr_en while port off");

endmodule

`default_nettype wire

// File: list.f
hdl/pif_pkg.sv
hdl/pif_wr_fsm.sv
hdl/pif_wr_assembler.sv
hdl/pif_rd_serializer.sv
hdl/fcb_pif_top.sv
test/pif_tb.sv

// File: test/pif_tb.sv
// Directed testbench for the parallel configuration port
// Clock, reset, timeout, compare task and a config read FIFO model
// Short, long, burst, fixed-address, read-back and port-off tests
`default_nettype none

module pif_tb;

  import pif_pkg::*;

  localparam int TIMEOUT_CYCLES = 400;  // Tests take under 100 cycles
  localparam int FIFO_DEPTH     = 8;

  logic          fcb_sys_clk;
  logic          fcb_sys_rst_n;
  logic          fcb_sys_stm;
  logic          fcb_pif_en;
  logic          fcb_pif_vldi;
  logic [7:0]    fcb_pif_di;
  logic          frwf_crf_empty;
  logic [31:0]   frwf_crf_rd_data;
  pif_pad_t      fcb_pif_pad;
  logic          fpif_frwf_pif_on;
  logic          fpif_frwf_wff_wr_en;
  logic          fpif_frwf_crf_rd_en;
  pif_wr_entry_t fpif_frwf_wff_wr_data;

  logic [31:0] fifo_mem [0:FIFO_DEPTH-1];  // Read FIFO model storage
  int          wr_ptr;
  int          rd_ptr;
  int          cycle_count;

  fcb_pif_top fcb_pif_top_i (
    .fcb_sys_clk           (fcb_sys_clk),
    .fcb_sys_rst_n         (fcb_sys_rst_n),
    .fcb_sys_stm           (fcb_sys_stm),
    .fcb_pif_en            (fcb_pif_en),
    .fcb_pif_vldi          (fcb_pif_vldi),
    .fcb_pif_di            (fcb_pif_di),
    .frwf_crf_empty        (frwf_crf_empty),
    .frwf_crf_rd_data      (frwf_crf_rd_data),
    .fcb_pif_pad           (fcb_pif_pad),
    .fpif_frwf_pif_on      (fpif_frwf_pif_on),
    .fpif_frwf_wff_wr_en   (fpif_frwf_wff_wr_en),
    .fpif_frwf_crf_rd_en   (fpif_frwf_crf_rd_en),
    .fpif_frwf_wff_wr_data (fpif_frwf_wff_wr_data)
  );

  initial
  begin
    fcb_sys_clk = 1'b0;
    forever #5 fcb_sys_clk = ~fcb_sys_clk;
  end

  // FIFO model, head word shown while not empty
  assign frwf_crf_empty   = (rd_ptr == wr_ptr);
  assign frwf_crf_rd_data = fifo_mem[rd_ptr % FIFO_DEPTH];

  always @(posedge fcb_sys_clk)
  begin
    if (fpif_frwf_crf_rd_en)
    begin
      rd_ptr <= rd_ptr + 1;  // Pop on rd_en
    end
  end

  always @(posedge fcb_sys_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $fatal(1, "Run stopped by timeout");
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // One host cycle, then wait to mid-cycle where outputs are settled
  task automatic drive_cycle(input logic valid, input logic [7:0] data);
    @(posedge fcb_sys_clk);
    fcb_pif_vldi <= valid;
    fcb_pif_di   <= data;
    @(negedge fcb_sys_clk);
  endtask

  task automatic set_port(input logic stm, input logic en);
    @(posedge fcb_sys_clk);
    fcb_sys_stm  <= stm;
    fcb_pif_en   <= en;
    fcb_pif_vldi <= 1'b0;
    @(negedge fcb_sys_clk);
    check_value(fpif_frwf_pif_on, stm & en, "pif_on");
    check_value(fcb_pif_pad.vldo_en, stm & en, "vldo_en");
  endtask

  task automatic test_reset_state();
    @(negedge fcb_sys_clk);
    check_value(fpif_frwf_wff_wr_en, 0, "wr_en after reset");
    check_value(fpif_frwf_crf_rd_en, 0, "rd_en after reset");
    check_value(fcb_pif_pad.vldo, 0, "vldo after reset");
    check_value(fcb_pif_pad.vldo_en, 0, "vldo_en after reset");
    check_value(fcb_pif_pad.dout_en, 0, "dout_en after reset");
  endtask

  task automatic test_short_command();
    drive_cycle(1'b1, 8'h15);
    check_value(fpif_frwf_wff_wr_en, 0, "wr_en with short address");
    drive_cycle(1'b0, 8'h00);
    check_value(fpif_frwf_wff_wr_en, 1, "wr_en one cycle after short");
    check_value(fpif_frwf_wff_wr_data.addr, 8'h15, "short entry addr");
    check_value(fpif_frwf_wff_wr_data.data, 0, "short entry data");
    drive_cycle(1'b0, 8'h00);
    check_value(fpif_frwf_wff_wr_en, 0, "second wr_en after short");
  endtask

  // Address byte, then groups of four data bytes back to back
  task automatic write_burst(input logic [7:0] addr, input int groups);
    logic [7:0]  exp_addr;
    logic [31:0] exp_data;
    exp_addr = addr;
    drive_cycle(1'b1, addr);
    check_value(fpif_frwf_wff_wr_en, 0, "wr_en with long address");
    for (int g = 0; g < groups; g++)
    begin
      if (g > 0 && exp_addr != 8'hA0)
      begin
        exp_addr = exp_addr + 8'd1;  // 0xA0 holds
      end
      exp_data = $urandom;
      for (int k = 0; k < 4; k++)
      begin
        drive_cycle(1'b1, exp_data[8*k +: 8]);  // LSB first
        check_value(fpif_frwf_wff_wr_en, (k == 3), "wr_en in data byte");
      end
      check_value(fpif_frwf_wff_wr_data.addr, exp_addr, "long entry addr");
      check_value(fpif_frwf_wff_wr_data.data, exp_data, "long entry data");
    end
    drive_cycle(1'b0, 8'h00);  // Gap ends the burst
    check_value(fpif_frwf_wff_wr_en, 0, "wr_en after burst");
  endtask

  task automatic test_long_burst();
    write_burst(8'hC2, 1);  // Single long write
    write_burst(8'h83, 3);  // Entries at 0x83, 0x84, 0x85
  endtask

  task automatic test_fixed_address();
    write_burst(8'hA0, 3);
  endtask

  task automatic test_read_back();
    logic [31:0] words [0:1];
    words[0] = $urandom;
    words[1] = $urandom;
    @(posedge fcb_sys_clk);
    fifo_mem[wr_ptr % FIFO_DEPTH]       <= words[0];
    fifo_mem[(wr_ptr + 1) % FIFO_DEPTH] <= words[1];
    wr_ptr                              <= wr_ptr + 2;
    for (int k = 0; k < 8; k++)
    begin
      @(negedge fcb_sys_clk);
      check_value(fcb_pif_pad.vldo, 1, "vldo in read-back");
      check_value(fcb_pif_pad.dout_en, 1, "dout_en in read-back");
      check_value(fcb_pif_pad.dout, words[k/4][8*(k%4) +: 8], "read-back byte");
      check_value(fpif_frwf_crf_rd_en, (k % 4 == 3), "rd_en in read-back");
    end
    @(negedge fcb_sys_clk);
    check_value(fcb_pif_pad.vldo, 0, "vldo with FIFO empty");
    check_value(fpif_frwf_crf_rd_en, 0, "rd_en with FIFO empty");
  endtask

  task automatic test_port_off();
    set_port(1'b1, 1'b0);
    @(posedge fcb_sys_clk);
    fifo_mem[wr_ptr % FIFO_DEPTH] <= $urandom;  // Word waits while off
    wr_ptr                        <= wr_ptr + 1;
    for (int k = 0; k < 6; k++)
    begin
      drive_cycle(k[0], (k < 3) ? 8'h15 : 8'h83);
      check_value(fpif_frwf_wff_wr_en, 0, "wr_en while off");
      check_value(fpif_frwf_crf_rd_en, 0, "rd_en while off");
      check_value(fcb_pif_pad.vldo, 0, "vldo while off");
      check_value(fcb_pif_pad.dout_en, 0, "dout_en while off");
      check_value(fcb_pif_pad.vldo_en, 0, "vldo_en while off");
      check_value(fpif_frwf_pif_on, 0, "pif_on while off");
    end
  endtask

  initial
  begin
    void'($urandom(32'he40));
    fcb_sys_rst_n = 1'b0;
    fcb_sys_stm   = 1'b0;
    fcb_pif_en    = 1'b0;
    fcb_pif_vldi  = 1'b0;
    fcb_pif_di    = 8'h00;
    wr_ptr        = 0;
    rd_ptr        = 0;
    cycle_count   = 0;
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      fifo_mem[i] = 32'hF1F0_0000 + i;  // Index in every word
    end
    repeat (4) @(posedge fcb_sys_clk);
    fcb_sys_rst_n <= 1'b1;

    test_reset_state();
    set_port(1'b1, 1'b1);  // Sequencers leave OFF on the next edge
    test_short_command();
    test_long_burst();
    test_fixed_address();
    test_read_back();
    test_port_off();

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
